// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_box_filter
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The run passes only when the pass message shows up in the simulator output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
logic/img_pkg.sv
logic/apb_pkg.sv
logic/frame_mem.sv
logic/window_padder.sv
logic/window_sum.sv
logic/result_mem.sv
logic/filter_ctrl.sv
logic/box_filter_top.sv
testbench/tb_box_filter.sv

// File: logic/apb_pkg.sv
package apb_pkg;

    localparam int APB_AW = 12;

    typedef logic [APB_AW-1:0] apb_addr_t;
    typedef logic [31:0]       apb_data_t;

    // Register map.
    localparam apb_addr_t PIX_BASE    = 12'h000;
    localparam apb_addr_t CTRL_ADDR   = 12'h100;
    localparam apb_addr_t STATUS_ADDR = 12'h104;
    localparam apb_addr_t RES_BASE    = 12'h200;

    // Control and status bit positions.
    localparam int CTRL_START_BIT = 0;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage

// File: logic/box_filter_top.sv
`timescale 1ns/1ps

module box_filter_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  apb_pkg::apb_addr_t paddr_i,
    input  apb_pkg::apb_data_t pwdata_i,
    output apb_pkg::apb_data_t prdata_o,
    output logic               pready_o,
    output logic               pslverr_o
);
    import img_pkg::*;

    logic     pix_we;
    pix_idx_t pix_widx;
    pixel_t   pix_wdata;
    coord_t   rd_row;
    coord_t   rd_col;
    column_t  frame_col;
    logic     shift_en;
    logic     out_en;
    coord_t   ctr_row;
    coord_t   ctr_col;
    window_t  win;
    logic     win_valid;
    sum_t     sum;
    logic     sum_valid;
    pix_idx_t res_widx;
    pix_idx_t res_ridx;
    sum_t     res_rdata;

    filter_ctrl ctrl0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .pix_we_o    (pix_we),
        .pix_widx_o  (pix_widx),
        .pix_wdata_o (pix_wdata),
        .rd_row_o    (rd_row),
        .rd_col_o    (rd_col),
        .shift_en_o  (shift_en),
        .out_en_o    (out_en),
        .ctr_row_o   (ctr_row),
        .ctr_col_o   (ctr_col),
        .res_widx_o  (res_widx),
        .res_ridx_o  (res_ridx),
        .res_rdata_i (res_rdata),
        .sum_valid_i (sum_valid)
    );

    frame_mem frame0 (
        .clk     (clk),
        .we_i    (pix_we),
        .widx_i  (pix_widx),
        .wdata_i (pix_wdata),
        .row_i   (rd_row),
        .col_i   (rd_col),
        .col_o   (frame_col)
    );

    window_padder padder0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .col_i       (frame_col),
        .shift_en_i  (shift_en),
        .out_en_i    (out_en),
        .ctr_row_i   (ctr_row),
        .ctr_col_i   (ctr_col),
        .win_o       (win),
        .win_valid_o (win_valid)
    );

    window_sum sum0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .win_i       (win),
        .win_valid_i (win_valid),
        .sum_o       (sum),
        .sum_valid_o (sum_valid)
    );

    result_mem result0 (
        .clk     (clk),
        .we_i    (sum_valid),
        .widx_i  (res_widx),
        .wdata_i (sum),
        .ridx_i  (res_ridx),
        .rdata_o (res_rdata)
    );

endmodule

// File: logic/filter_ctrl.sv
`timescale 1ns/1ps

module filter_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  apb_pkg::apb_addr_t paddr_i,
    input  apb_pkg::apb_data_t pwdata_i,
    output apb_pkg::apb_data_t prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    output logic               pix_we_o,
    output img_pkg::pix_idx_t  pix_widx_o,
    output img_pkg::pixel_t    pix_wdata_o,
    output img_pkg::coord_t    rd_row_o,
    output img_pkg::coord_t    rd_col_o,
    output logic               shift_en_o,
    output logic               out_en_o,
    output img_pkg::coord_t    ctr_row_o,
    output img_pkg::coord_t    ctr_col_o,
    output img_pkg::pix_idx_t  res_widx_o,
    output img_pkg::pix_idx_t  res_ridx_o,
    input  img_pkg::sum_t      res_rdata_i,
    input  logic               sum_valid_i
);
    import img_pkg::*;
    import apb_pkg::*;

    ctrl_state_t state_q;
    coord_t      row_q;
    feed_cnt_t   feed_q;
    logic        access;
    apb_addr_t   pix_off;
    apb_addr_t   res_off;
    logic        pix_hit;
    logic        ctrl_hit;
    logic        stat_hit;
    logic        res_hit;
    logic        busy;
    logic        done;
    logic        start;
    logic        feeding;
    logic        last_feed;
    logic        last_row;
    logic        last_sum;
    logic        s1_shift;
    logic        s1_out;
    logic        s2_out;
    coord_t      s1_row;
    coord_t      s1_col;
    coord_t      s2_row;
    coord_t      s2_col;
    pix_idx_t    idx_q [3];

    // Every APB transfer finishes in its access phase.
    assign access   = psel_i && penable_i;
    assign pix_off  = paddr_i - PIX_BASE;
    assign res_off  = paddr_i - RES_BASE;
    assign pix_hit  = (pix_off < apb_addr_t'(NUM_PIX * 4)) && (paddr_i[1:0] == 2'b00);
    assign res_hit  = (res_off < apb_addr_t'(NUM_PIX * 4)) && (paddr_i[1:0] == 2'b00);
    assign ctrl_hit = paddr_i == CTRL_ADDR;
    assign stat_hit = paddr_i == STATUS_ADDR;

    assign busy  = (state_q == FEED) || (state_q == DRAIN);
    assign done  = state_q == DONE;
    assign start = access && pwrite_i && ctrl_hit && pwdata_i[CTRL_START_BIT];

    assign pready_o  = 1'b1;
    assign pslverr_o = access && (!(pix_hit || ctrl_hit || stat_hit || res_hit)
                                  || (pwrite_i && (stat_hit || res_hit))
                                  || (pwrite_i && pix_hit && busy));

    assign pix_we_o    = access && pwrite_i && pix_hit && !busy;
    assign pix_widx_o  = pix_off[7:2];
    assign pix_wdata_o = pwdata_i[7:0];
    assign res_ridx_o  = res_off[7:2];

    always_comb begin
        prdata_o = '0;
        if (stat_hit) begin
            prdata_o[STAT_BUSY_BIT] = busy;
            prdata_o[STAT_DONE_BIT] = done;
        end else if (res_hit) begin
            prdata_o = apb_data_t'(res_rdata_i);
        end
    end

    assign feeding   = state_q == FEED;
    assign last_feed = feed_q == feed_cnt_t'(FEED_CYCLES - 1);
    assign last_row  = row_q == coord_t'(IMG_ROWS - 1);
    assign last_sum  = sum_valid_i && (res_widx_o == pix_idx_t'(NUM_PIX - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            row_q   <= '0;
            feed_q  <= '0;
        end else begin
            case (state_q)
                IDLE, DONE: begin
                    if (start) begin
                        state_q <= FEED;
                        row_q   <= '0;
                        feed_q  <= '0;
                    end
                end
                FEED: begin
                    if (last_feed) begin
                        feed_q <= '0;
                        row_q  <= row_q + 1'b1;
                        if (last_row) begin
                            state_q <= DRAIN;
                        end
                    end else begin
                        feed_q <= feed_q + 1'b1;
                    end
                end
                DRAIN: begin
                    if (last_sum) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Frame read data lands one cycle later and the window is centred a cycle after that.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_shift <= 1'b0;
            s1_out   <= 1'b0;
            s2_out   <= 1'b0;
        end else begin
            s1_shift <= feeding;
            s1_out   <= feeding && (feed_q >= feed_cnt_t'(WIN_R));
            s2_out   <= s1_out;
        end
    end

    // Result index follows the padder and the two adder stages.
    always_ff @(posedge clk) begin
        s1_row   <= row_q;
        s1_col   <= coord_t'(feed_q - feed_cnt_t'(WIN_R));
        s2_row   <= s1_row;
        s2_col   <= s1_col;
        idx_q[0] <= pix_idx_t'(int'(s2_row) * IMG_COLS + int'(s2_col));
        idx_q[1] <= idx_q[0];
        idx_q[2] <= idx_q[1];
    end

    assign rd_row_o   = row_q;
    assign rd_col_o   = coord_t'(feed_q);
    assign shift_en_o = s1_shift;
    assign out_en_o   = s2_out;
    assign ctr_row_o  = s2_row;
    assign ctr_col_o  = s2_col;
    assign res_widx_o = idx_q[2];

endmodule

// File: logic/frame_mem.sv
`timescale 1ns/1ps

module frame_mem (
    input  logic              clk,
    input  logic              we_i,
    input  img_pkg::pix_idx_t widx_i,
    input  img_pkg::pixel_t   wdata_i,
    input  img_pkg::coord_t   row_i,
    input  img_pkg::coord_t   col_i,
    output img_pkg::column_t  col_o
);
    import img_pkg::*;

    pixel_t  mem [NUM_PIX] = '{default: '0};
    column_t rd_col;

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[widx_i] <= wdata_i;
        end
    end

    // Reads rows row_i-3 to row_i+3 with the top row in the lowest byte.
    always_comb begin
        int src;
        rd_col = '0;
        for (int k = 0; k < WIN_W; k++) begin
            src = int'(row_i) + k - WIN_R;
            if (src >= 0 && src < IMG_ROWS && int'(col_i) < IMG_COLS) begin
                rd_col[k * PIX_W +: PIX_W] = mem[src * IMG_COLS + int'(col_i)];
            end
        end
    end

    always_ff @(posedge clk) begin
        col_o <= rd_col;
    end

endmodule

// File: logic/img_pkg.sv
package img_pkg;

    // Fixed image and window geometry.
    localparam int IMG_ROWS    = 7;
    localparam int IMG_COLS    = 7;
    localparam int WIN_R       = 3;
    localparam int WIN_W       = 2 * WIN_R + 1;
    localparam int NUM_PIX     = IMG_ROWS * IMG_COLS;
    localparam int PIX_W       = 8;
    localparam int SUM_W       = 14;

    // Columns fed per output row, including the trailing pad columns.
    localparam int FEED_CYCLES = IMG_COLS + WIN_R;

    typedef logic [PIX_W-1:0]             pixel_t;
    typedef logic [WIN_W*PIX_W-1:0]       column_t;
    typedef logic [WIN_W*WIN_W*PIX_W-1:0] window_t;
    typedef logic [SUM_W-1:0]             sum_t;
    typedef logic [2:0]                   coord_t;
    typedef logic [5:0]                   pix_idx_t;
    typedef logic [3:0]                   feed_cnt_t;

    typedef enum logic [1:0] {
        IDLE,
        FEED,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

// File: logic/result_mem.sv
`timescale 1ns/1ps

module result_mem (
    input  logic              clk,
    input  logic              we_i,
    input  img_pkg::pix_idx_t widx_i,
    input  img_pkg::sum_t     wdata_i,
    input  img_pkg::pix_idx_t ridx_i,
    output img_pkg::sum_t     rdata_o
);
    import img_pkg::*;

    sum_t mem [NUM_PIX] = '{default: '0};

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[widx_i] <= wdata_i;
        end
    end

    // Combinational read for the APB access phase.
    assign rdata_o = (int'(ridx_i) < NUM_PIX) ? mem[ridx_i] : '0;

endmodule

// File: logic/window_padder.sv
`timescale 1ns/1ps

module window_padder (
    input  logic             clk,
    input  logic             rst_n,
    input  img_pkg::column_t col_i,
    input  logic             shift_en_i,
    input  logic             out_en_i,
    input  img_pkg::coord_t  ctr_row_i,
    input  img_pkg::coord_t  ctr_col_i,
    output img_pkg::window_t win_o,
    output logic             win_valid_o
);
    import img_pkg::*;

    column_t          cols_q [WIN_W];
    logic [WIN_W-1:0] row_ok;
    logic [WIN_W-1:0] col_ok;
    window_t          win_d;

    // Entry 0 holds the oldest column, the left edge of the window.
    always_ff @(posedge clk) begin
        if (shift_en_i) begin
            for (int j = 0; j < WIN_W - 1; j++) begin
                cols_q[j] <= cols_q[j + 1];
            end
            cols_q[WIN_W - 1] <= col_i;
        end
    end

    // Taps whose image row or column falls outside the frame read as zero.
    always_comb begin
        int r;
        int c;
        for (int k = 0; k < WIN_W; k++) begin
            r = int'(ctr_row_i) + k - WIN_R;
            row_ok[k] = (r >= 0) && (r < IMG_ROWS);
        end
        for (int j = 0; j < WIN_W; j++) begin
            c = int'(ctr_col_i) + j - WIN_R;
            col_ok[j] = (c >= 0) && (c < IMG_COLS);
        end
        for (int k = 0; k < WIN_W; k++) begin
            for (int j = 0; j < WIN_W; j++) begin
                win_d[(k * WIN_W + j) * PIX_W +: PIX_W] =
                    (row_ok[k] && col_ok[j]) ? cols_q[j][k * PIX_W +: PIX_W] : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_en_i) begin
            win_o <= win_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid_o <= 1'b0;
        end else begin
            win_valid_o <= out_en_i;
        end
    end

endmodule

// File: logic/window_sum.sv
`timescale 1ns/1ps

module window_sum (
    input  logic             clk,
    input  logic             rst_n,
    input  img_pkg::window_t win_i,
    input  logic             win_valid_i,
    output img_pkg::sum_t    sum_o,
    output logic             sum_valid_o
);
    import img_pkg::*;

    sum_t row_sum_d [WIN_W];
    sum_t row_sum_q [WIN_W];
    sum_t total_d;
    logic valid_q;

    // Stage one adds the taps of each window row.
    always_comb begin
        for (int k = 0; k < WIN_W; k++) begin
            row_sum_d[k] = '0;
            for (int j = 0; j < WIN_W; j++) begin
                row_sum_d[k] = row_sum_d[k] + sum_t'(win_i[(k * WIN_W + j) * PIX_W +: PIX_W]);
            end
        end
    end

    // Stage two adds the row sums.
    always_comb begin
        total_d = '0;
        for (int k = 0; k < WIN_W; k++) begin
            total_d = total_d + row_sum_q[k];
        end
    end

    always_ff @(posedge clk) begin
        row_sum_q <= row_sum_d;
        sum_o     <= total_d;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            sum_valid_o <= 1'b0;
        end else begin
            valid_q     <= win_valid_i;
            sum_valid_o <= valid_q;
        end
    end

endmodule

// File: testbench/tb_box_filter.sv
`timescale 1ns/1ps

module tb_box_filter;
    import img_pkg::*;
    import apb_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int APB_CYCLES   = 3;
    localparam int NUM_FRAMES   = 6;
    localparam int POLL_LIMIT   = 200;
    // Load, filter and read back one frame, with slack for status polling.
    localparam int FRAME_CYCLES = 2 * NUM_PIX * APB_CYCLES + IMG_ROWS * (IMG_COLS + 3) + 64;
    localparam int RESET_READS  = (NUM_PIX + 1) * APB_CYCLES;
    localparam longint WATCHDOG_NS =
        longint'(RESET_CYCLES + RESET_READS + (NUM_FRAMES + 2) * FRAME_CYCLES) * CLK_PERIOD * 2;

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    pixel_t      frame [NUM_PIX];
    logic [31:0] rng;
    int          errors;
    int          checks;

    box_filter_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation stopped by the watchdog: the tests did not finish in time.");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Sum of every in-bounds pixel within 3 rows and 3 columns of (r, c).
    function automatic sum_t model_sum(input int r, input int c);
        int acc;
        acc = 0;
        for (int rr = r - 3; rr <= r + 3; rr++) begin
            for (int cc = c - 3; cc <= c + 3; cc++) begin
                if (rr >= 0 && rr < IMG_ROWS && cc >= 0 && cc < IMG_COLS) begin
                    acc = acc + int'(frame[rr * IMG_COLS + cc]);
                end
            end
        end
        return sum_t'(acc);
    endfunction

    // Number of indices in 0..n-1 that lie within 3 of p.
    function automatic int in_range(input int p, input int n);
        int lo;
        int hi;
        lo = (p - 3 < 0) ? 0 : p - 3;
        hi = (p + 3 > n - 1) ? n - 1 : p + 3;
        return hi - lo + 1;
    endfunction

    task automatic check_sum(input string name, input sum_t got, input sum_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Outputs are sampled halfway through the access phase that follows the setup phase.
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        check_bit("pready", pready, 1'b1);
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        check_bit("pready", pready, 1'b1);
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic fill_random();
        for (int i = 0; i < NUM_PIX; i++) begin
            rng      = xorshift32(rng);
            frame[i] = rng[15:8];
        end
    endtask

    task automatic load_frame();
        logic err;
        for (int i = 0; i < NUM_PIX; i++) begin
            apb_write(apb_addr_t'(PIX_BASE + 4 * i), {24'h0, frame[i]}, err);
            check_bit("pslverr", err, 1'b0);
        end
    endtask

    task automatic start_filter();
        logic err;
        apb_write(CTRL_ADDR, 32'h1, err);
        check_bit("pslverr", err, 1'b0);
    endtask

    task automatic wait_done();
        apb_data_t status;
        logic      err;
        logic      seen;
        int        polls;
        seen  = 1'b0;
        polls = 0;
        while (!seen && polls < POLL_LIMIT) begin
            apb_read(STATUS_ADDR, status, err);
            polls++;
            seen = status[STAT_DONE_BIT];
        end
        if (!seen) begin
            errors++;
            $display("Frame did not finish: done bit still clear after %0d status reads",
                     POLL_LIMIT);
        end else begin
            check_bit("status.busy", status[STAT_BUSY_BIT], 1'b0);
        end
    endtask

    task automatic check_results(input string tag);
        apb_data_t data;
        logic      err;
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                apb_read(apb_addr_t'(RES_BASE + 4 * (r * IMG_COLS + c)), data, err);
                check_bit("pslverr", err, 1'b0);
                check_sum($sformatf("%s sum[%0d][%0d]", tag, r, c), sum_t'(data),
                          model_sum(r, c));
            end
        end
    endtask

    task automatic run_frame(input string tag);
        load_frame();
        start_filter();
        wait_done();
        check_results(tag);
    endtask

    initial begin
        apb_data_t data;
        logic      err;
        sum_t      exp;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rng     = 32'd37136;
        errors  = 0;
        checks  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle status and a cleared result memory after reset.
        apb_read(STATUS_ADDR, data, err);
        check_bit("status.busy", data[STAT_BUSY_BIT], 1'b0);
        check_bit("status.done", data[STAT_DONE_BIT], 1'b0);
        for (int i = 0; i < NUM_PIX; i++) begin
            apb_read(apb_addr_t'(RES_BASE + 4 * i), data, err);
            check_sum($sformatf("reset sum[%0d]", i), sum_t'(data), '0);
        end

        fill_random();
        run_frame("random");

        // Each sum of a saturated frame is 255 times the in-bounds neighbour count.
        for (int i = 0; i < NUM_PIX; i++) begin
            frame[i] = 8'hFF;
        end
        load_frame();
        start_filter();
        wait_done();
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                apb_read(apb_addr_t'(RES_BASE + 4 * (r * IMG_COLS + c)), data, err);
                exp = sum_t'(255 * in_range(r, IMG_ROWS) * in_range(c, IMG_COLS));
                check_sum($sformatf("full sum[%0d][%0d]", r, c), sum_t'(data), exp);
            end
        end

        for (int k = 0; k < 3; k++) begin
            fill_random();
            run_frame($sformatf("frame %0d", k));
        end

        // Error responses.
        apb_read(12'h300, data, err);
        check_bit("pslverr (unmapped read)", err, 1'b1);
        apb_write(RES_BASE, 32'h1234, err);
        check_bit("pslverr (result write)", err, 1'b1);

        // A pixel write while busy is refused and leaves the frame alone.
        fill_random();
        load_frame();
        start_filter();
        apb_read(STATUS_ADDR, data, err);
        check_bit("status.busy", data[STAT_BUSY_BIT], 1'b1);
        apb_write(apb_addr_t'(PIX_BASE + 4 * 24), {24'h0, ~frame[24]}, err);
        check_bit("pslverr (pixel write while busy)", err, 1'b1);
        wait_done();
        check_results("busy write");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
